//--- Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		-f pmod_uart_top.f --top-module pmod_uart_tb -Mdir obj_dir
	./obj_dir/Vpmod_uart_tb | tee $(LOG)
	@grep -q "^PASS: all tests$$" $(LOG) || (echo "simulation failed"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

//--- common/pmod_uart_pkg.sv
package pmod_uart_pkg;

    // ------------------------------
    //  bus side
    // ------------------------------

    // word address of a peripheral register
    typedef logic   [3:0]   bus_addr_t;
    typedef logic   [31:0]  bus_data_t;

    // ------------------------------
    //  serial and pins
    // ------------------------------

    typedef logic   [7:0]   uart_byte_t;

    // clocks per serial bit minus one
    typedef logic   [15:0]  divider_t;

    typedef logic   [3:0]   gpio_t;

    // register map
    localparam  bus_addr_t  ADDR_TX      = 4'd0;
    localparam  bus_addr_t  ADDR_RX      = 4'd1;
    localparam  bus_addr_t  ADDR_STATUS  = 4'd2;
    localparam  bus_addr_t  ADDR_DIVIDER = 4'd3;
    localparam  bus_addr_t  ADDR_GPIO    = 4'd4;

endpackage

//--- pmod_uart_top.f
common/pmod_uart_pkg.sv
source/bus_regs.sv
uart/uart_tx.sv
uart/uart_rx.sv
source/pmod_driver.sv
source/pmod_uart_top.sv
test/pmod_uart_tb.sv

//--- source/bus_regs.sv
`timescale 1ns/1ns
`default_nettype none

module bus_regs
        #(
            parameter   pmod_uart_pkg::divider_t    INIT_DIVIDER = 16'd216
        )
        (
            input   var logic                       clk,
            input   var logic                       reset,
            input   var logic                       bus_wr_en,
            input   var logic                       bus_rd_en,
            input   var pmod_uart_pkg::bus_addr_t   bus_addr,
            input   var pmod_uart_pkg::bus_data_t   bus_wdata,
            output  var pmod_uart_pkg::bus_data_t   bus_rdata,
            output  var logic                       bus_rd_valid,
            output  var logic                       tx_start,
            output  var pmod_uart_pkg::uart_byte_t  tx_data,
            input   var logic                       tx_busy,
            input   var logic                       rx_valid,
            input   var pmod_uart_pkg::uart_byte_t  rx_data,
            output  var pmod_uart_pkg::divider_t    divider,
            output  var pmod_uart_pkg::gpio_t       gpio
        );

    import pmod_uart_pkg::*;

    logic       wr_tx;
    logic       wr_divider;
    logic       wr_gpio;
    logic       rd_rx;
    uart_byte_t rx_hold;
    logic       rx_full;
    logic       rx_overrun;
    bus_data_t  rd_mux;

    // address decode
    assign wr_tx      = bus_wr_en && (bus_addr == ADDR_TX);
    assign wr_divider = bus_wr_en && (bus_addr == ADDR_DIVIDER);
    assign wr_gpio    = bus_wr_en && (bus_addr == ADDR_GPIO);
    assign rd_rx      = bus_rd_en && (bus_addr == ADDR_RX);

    // write to a busy transmitter is dropped
    assign tx_start = wr_tx && !tx_busy;
    assign tx_data  = bus_wdata[7:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            divider <= INIT_DIVIDER;
            gpio    <= '0;
        end else begin
            if (wr_divider) begin
                divider <= bus_wdata[15:0];
            end
            if (wr_gpio) begin
                gpio <= bus_wdata[3:0];
            end
        end
    end

    // new byte wins over a read in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_hold    <= '0;
            rx_full    <= 1'b0;
            rx_overrun <= 1'b0;
        end else if (rx_valid) begin
            rx_hold    <= rx_data;
            rx_full    <= 1'b1;
            rx_overrun <= rd_rx ? 1'b0 : (rx_overrun | rx_full);
        end else if (rd_rx) begin
            rx_full    <= 1'b0;
            rx_overrun <= 1'b0;
        end
    end

    // tx and unmapped addresses read as zero
    always_comb begin
        case (bus_addr)
            ADDR_RX:      rd_mux = {22'd0, rx_overrun, rx_full, rx_hold};
            ADDR_STATUS:  rd_mux = {29'd0, rx_overrun, rx_full, tx_busy};
            ADDR_DIVIDER: rd_mux = {16'd0, divider};
            ADDR_GPIO:    rd_mux = {28'd0, gpio};
            default:      rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bus_rd_valid <= 1'b0;
        end else begin
            bus_rd_valid <= bus_rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (bus_rd_en) begin
            bus_rdata <= rd_mux;
        end
    end

    a_strobes_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(bus_wr_en && bus_rd_en));

endmodule

`default_nettype wire

//--- source/pmod_driver.sv
`timescale 1ns/1ns
`default_nettype none

module pmod_driver
        #(
            parameter   int     HEARTBEAT_BITS = 28
        )
        (
            input   var logic                   clk,
            input   var logic                   reset,
            input   var pmod_uart_pkg::gpio_t   gpio,
            input   var logic                   rx_busy,
            input   var logic                   tx_line,
            output  var logic   [7:0]           pmod
        );

    logic   [HEARTBEAT_BITS-1:0]    heartbeat;

    // free running heartbeat
    always_ff @(posedge clk) begin
        if (reset) begin
            heartbeat <= '0;
        end else begin
            heartbeat <= heartbeat + 1'b1;
        end
    end

    // ------------------------------
    //  pin register
    // ------------------------------

    // pins straight from flops, tx idles high
    always_ff @(posedge clk) begin
        if (reset) begin
            pmod <= 8'b0010_0000;
        end else begin
            pmod <= {
                heartbeat[HEARTBEAT_BITS-1 -: 2],
                tx_line,
                rx_busy,
                gpio
            };
        end
    end

endmodule

`default_nettype wire

//--- source/pmod_uart_top.sv
`timescale 1ns/1ns
`default_nettype none

module pmod_uart_top
        #(
            parameter   pmod_uart_pkg::divider_t    INIT_DIVIDER   = 16'd216,
            parameter   int                         HEARTBEAT_BITS = 28
        )
        (
            input   var logic                       clk,
            input   var logic                       reset,
            input   var logic                       bus_wr_en,
            input   var logic                       bus_rd_en,
            input   var pmod_uart_pkg::bus_addr_t   bus_addr,
            input   var pmod_uart_pkg::bus_data_t   bus_wdata,
            output  var pmod_uart_pkg::bus_data_t   bus_rdata,
            output  var logic                       bus_rd_valid,
            input   var logic                       uart_rx,
            output  var logic   [7:0]               pmod
        );

    import pmod_uart_pkg::*;

    logic       tx_start;
    uart_byte_t tx_data;
    logic       tx_busy;
    logic       tx_line;
    logic       rx_valid;
    uart_byte_t rx_data;
    logic       rx_busy;
    divider_t   divider;
    gpio_t      gpio;

    // ------------------------------
    //  registers
    // ------------------------------
    bus_regs
            #(
                .INIT_DIVIDER   (INIT_DIVIDER   )
            )
        u_bus_regs
            (
                .clk            (clk            ),
                .reset          (reset          ),
                .bus_wr_en      (bus_wr_en      ),
                .bus_rd_en      (bus_rd_en      ),
                .bus_addr       (bus_addr       ),
                .bus_wdata      (bus_wdata      ),
                .bus_rdata      (bus_rdata      ),
                .bus_rd_valid   (bus_rd_valid   ),
                .tx_start       (tx_start       ),
                .tx_data        (tx_data        ),
                .tx_busy        (tx_busy        ),
                .rx_valid       (rx_valid       ),
                .rx_data        (rx_data        ),
                .divider        (divider        ),
                .gpio           (gpio           )
            );

    // ------------------------------
    //  uart
    // ------------------------------
    uart_tx
        u_uart_tx
            (
                .clk            (clk            ),
                .reset          (reset          ),
                .tx_start       (tx_start       ),
                .tx_data        (tx_data        ),
                .divider        (divider        ),
                .tx_busy        (tx_busy        ),
                .tx_line        (tx_line        )
            );

    uart_rx
        u_uart_rx
            (
                .clk            (clk            ),
                .reset          (reset          ),
                .rx_line        (uart_rx        ),
                .divider        (divider        ),
                .rx_valid       (rx_valid       ),
                .rx_data        (rx_data        ),
                .rx_busy        (rx_busy        )
            );

    // pins
    pmod_driver
            #(
                .HEARTBEAT_BITS (HEARTBEAT_BITS )
            )
        u_pmod_driver
            (
                .clk            (clk            ),
                .reset          (reset          ),
                .gpio           (gpio           ),
                .rx_busy        (rx_busy        ),
                .tx_line        (tx_line        ),
                .pmod           (pmod           )
            );

endmodule

`default_nettype wire

//--- test/pmod_uart_tb.sv
`timescale 1ns/1ns

module pmod_uart_tb;

    import pmod_uart_pkg::*;

    logic       clk;
    logic       reset;
    logic       bus_wr_en;
    logic       bus_rd_en;
    bus_addr_t  bus_addr;
    bus_data_t  bus_wdata;
    bus_data_t  bus_rdata;
    logic       bus_rd_valid;
    logic       rx_pin;
    logic [7:0] pmod;

    // expected register contents
    divider_t   exp_divider;
    gpio_t      exp_gpio;
    uart_byte_t exp_rx_byte;
    logic       exp_rx_valid;
    logic       exp_overrun;
    logic       exp_tx_busy;
    bus_data_t  exp_q[$];

    int errors;
    int test_errors;
    int tests_run;
    int tests_failed;

    pmod_uart_top
            #(
                .INIT_DIVIDER   (16'd7          ),
                .HEARTBEAT_BITS (6              )
            )
        u_dut
            (
                .clk            (clk            ),
                .reset          (reset          ),
                .bus_wr_en      (bus_wr_en      ),
                .bus_rd_en      (bus_rd_en      ),
                .bus_addr       (bus_addr       ),
                .bus_wdata      (bus_wdata      ),
                .bus_rdata      (bus_rdata      ),
                .bus_rd_valid   (bus_rd_valid   ),
                .uart_rx        (rx_pin         ),
                .pmod           (pmod           )
            );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic bus_data_t expected_read(input bus_addr_t addr);
        bus_data_t value;
        value = '0;
        case (addr)
            ADDR_RX: begin
                value[7:0] = exp_rx_byte;
                value[8]   = exp_rx_valid;
                value[9]   = exp_overrun;
            end
            ADDR_STATUS: begin
                value[0] = exp_tx_busy;
                value[1] = exp_rx_valid;
                value[2] = exp_overrun;
            end
            ADDR_DIVIDER: value[15:0] = exp_divider;
            ADDR_GPIO:    value[3:0]  = exp_gpio;
            default:      value       = '0;
        endcase
        return value;
    endfunction

    // ------------------------------
    //  read data compare
    // ------------------------------
    always @(negedge clk) begin
        bus_data_t exp_value;
        if (bus_rd_valid) begin
            if (exp_q.size() == 0) begin
                $display("ERROR: read data returned with no read pending");
                errors++;
            end else begin
                exp_value = exp_q.pop_front();
                assert (bus_rdata == exp_value) else begin
                    $display("FAIL %0t ns bus_rdata got %h expected %h",
                             $time, bus_rdata, exp_value);
                    errors++;
                end
            end
        end
    end

    task automatic bus_write(input bus_addr_t addr, input bus_data_t data);
        @(posedge clk);
        bus_wr_en <= 1'b1;
        bus_addr  <= addr;
        bus_wdata <= data;
        @(posedge clk);
        bus_wr_en <= 1'b0;
        if (addr == ADDR_DIVIDER) begin
            exp_divider = data[15:0];
        end
        if (addr == ADDR_GPIO) begin
            exp_gpio = data[3:0];
        end
    endtask

    task automatic bus_read(input bus_addr_t addr, output bus_data_t data);
        int wait_cnt;
        @(posedge clk);
        bus_rd_en <= 1'b1;
        bus_addr  <= addr;
        exp_q.push_back(expected_read(addr));
        // flags clear on the read
        if (addr == ADDR_RX) begin
            exp_rx_valid = 1'b0;
            exp_overrun  = 1'b0;
        end
        @(posedge clk);
        bus_rd_en <= 1'b0;
        wait_cnt = 0;
        @(negedge clk);
        while (!bus_rd_valid && wait_cnt < 20) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!bus_rd_valid) begin
            $display("ERROR: no read valid for address %0d", addr);
            errors++;
        end
        data = bus_rdata;
    endtask

    task automatic send_serial(input uart_byte_t value, input logic stop_level);
        int         bit_clks;
        logic [9:0] frame;
        bit_clks = int'(exp_divider) + 1;
        frame    = {stop_level, value, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rx_pin <= frame[i];
            // receiver busy once the start bit is seen
            @(negedge clk);
            assert (pmod[4] == (i > 0)) else begin
                $display("FAIL %0t ns pmod[4] got %b expected %b", $time, pmod[4], i > 0);
                errors++;
            end
            repeat (bit_clks - 1) @(posedge clk);
        end
        @(posedge clk);
        rx_pin <= 1'b1;
        if (stop_level) begin
            exp_overrun  = exp_rx_valid;
            exp_rx_byte  = value;
            exp_rx_valid = 1'b1;
        end
    endtask

    // samples pmod[5] at bit centres
    task automatic capture_serial(output uart_byte_t value);
        int bit_clks;
        int wait_cnt;
        bit_clks = int'(exp_divider) + 1;
        value    = '0;
        wait_cnt = 0;
        @(negedge clk);
        while (pmod[5] && wait_cnt < 100) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (pmod[5]) begin
            $display("ERROR: no start bit seen on pmod[5]");
            errors++;
        end else begin
            repeat (bit_clks / 2) @(negedge clk);
            assert (!pmod[5]) else begin
                $display("FAIL %0t ns pmod[5] start bit got 1 expected 0", $time);
                errors++;
            end
            for (int i = 0; i < 8; i++) begin
                repeat (bit_clks) @(negedge clk);
                value[i] = pmod[5];
            end
            repeat (bit_clks) @(negedge clk);
            assert (pmod[5]) else begin
                $display("FAIL %0t ns pmod[5] stop bit got 0 expected 1", $time);
                errors++;
            end
        end
    endtask

    task automatic report_test(input string name);
        @(posedge clk);
        tests_run++;
        if (errors == test_errors) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - test_errors);
            tests_failed++;
        end
        test_errors = errors;
    endtask

    // ------------------------------
    //  tests
    // ------------------------------
    task automatic test_reset();
        bus_data_t rdata;
        @(negedge clk);
        assert (pmod[3:0] == 4'd0) else begin
            $display("FAIL %0t ns pmod[3:0] got %h expected 0", $time, pmod[3:0]);
            errors++;
        end
        assert (!pmod[4]) else begin
            $display("FAIL %0t ns pmod[4] got 1 expected 0", $time);
            errors++;
        end
        assert (pmod[5]) else begin
            $display("FAIL %0t ns pmod[5] got 0 expected 1", $time);
            errors++;
        end
        bus_read(ADDR_DIVIDER, rdata);
        bus_read(ADDR_STATUS, rdata);
        bus_read(ADDR_RX, rdata);
    endtask

    task automatic test_gpio();
        gpio_t     value;
        bus_addr_t addr;
        bus_data_t rdata;
        for (int i = 0; i < 4; i++) begin
            value = 4'($urandom);
            bus_write(ADDR_GPIO, {28'd0, value});
            // gpio register, then pin register
            repeat (2) @(negedge clk);
            assert (pmod[3:0] == value) else begin
                $display("FAIL %0t ns pmod[3:0] got %h expected %h", $time, pmod[3:0], value);
                errors++;
            end
            bus_read(ADDR_GPIO, rdata);
        end
        // unmapped range 5 to 15
        addr = 4'(5 + ($urandom % 11));
        bus_write(addr, $urandom);
        bus_read(addr, rdata);
        bus_read(ADDR_GPIO, rdata);
        bus_read(ADDR_DIVIDER, rdata);
        @(negedge clk);
        assert (pmod[3:0] == exp_gpio) else begin
            $display("FAIL %0t ns pmod[3:0] got %h expected %h", $time, pmod[3:0], exp_gpio);
            errors++;
        end
    endtask

    task automatic test_transmit(input int frames);
        uart_byte_t value;
        uart_byte_t got;
        bus_data_t  rdata;
        int         bit_clks;
        int         low_cnt;
        for (int f = 0; f < frames; f++) begin
            value    = 8'($urandom);
            bit_clks = int'(exp_divider) + 1;
            bus_write(ADDR_TX, {24'd0, value});
            exp_tx_busy = 1'b1;
            fork
                capture_serial(got);
                begin
                    bus_read(ADDR_STATUS, rdata);
                    bus_read(ADDR_TX, rdata);
                    bus_write(ADDR_TX, {24'd0, ~value});
                end
            join
            assert (got == value) else begin
                $display("FAIL %0t ns pmod[5] byte got %h expected %h", $time, got, value);
                errors++;
            end
            // second write was dropped, line stays idle
            low_cnt = 0;
            repeat (2 * bit_clks) begin
                @(negedge clk);
                if (!pmod[5]) begin
                    low_cnt++;
                end
            end
            if (low_cnt != 0) begin
                $display("ERROR: a second frame appeared after a TX write while busy");
                errors++;
            end
            exp_tx_busy = 1'b0;
            bus_read(ADDR_STATUS, rdata);
        end
    endtask

    task automatic test_receive();
        bus_data_t rdata;
        for (int i = 0; i < 3; i++) begin
            send_serial(8'($urandom), 1'b1);
            bus_read(ADDR_RX, rdata);
            bus_read(ADDR_RX, rdata);
        end
        // two bytes without a read
        send_serial(8'($urandom), 1'b1);
        send_serial(8'($urandom), 1'b1);
        bus_read(ADDR_STATUS, rdata);
        bus_read(ADDR_RX, rdata);
        bus_read(ADDR_STATUS, rdata);
    endtask

    task automatic test_framing();
        bus_data_t rdata;
        send_serial(8'($urandom), 1'b1);
        send_serial(8'($urandom), 1'b0);
        repeat (int'(exp_divider) + 1) @(posedge clk);
        bus_read(ADDR_STATUS, rdata);
        bus_read(ADDR_RX, rdata);
    endtask

    task automatic test_heartbeat();
        logic [1:0] prev;
        int         wait_cnt;
        wait_cnt = 0;
        @(negedge clk);
        prev = pmod[7:6];
        @(negedge clk);
        while (!(prev == 2'd3 && pmod[7:6] == 2'd0) && wait_cnt < 200) begin
            prev = pmod[7:6];
            @(negedge clk);
            wait_cnt++;
        end
        if (!(prev == 2'd3 && pmod[7:6] == 2'd0)) begin
            $display("ERROR: heartbeat on pmod[7:6] never wrapped from 3 to 0");
            errors++;
        end else begin
            for (int step = 0; step < 4; step++) begin
                repeat (16) begin
                    assert (pmod[7:6] == 2'(step)) else begin
                        $display("FAIL %0t ns pmod[7:6] got %0d expected %0d",
                                 $time, pmod[7:6], step);
                        errors++;
                    end
                    @(negedge clk);
                end
            end
            assert (pmod[7:6] == 2'd0) else begin
                $display("FAIL %0t ns pmod[7:6] got %0d expected 0", $time, pmod[7:6]);
                errors++;
            end
        end
    endtask

    initial begin
        reset        = 1'b1;
        bus_wr_en    = 1'b0;
        bus_rd_en    = 1'b0;
        bus_addr     = '0;
        bus_wdata    = '0;
        rx_pin       = 1'b1;
        exp_divider  = 16'd7;
        exp_gpio     = '0;
        exp_rx_byte  = '0;
        exp_rx_valid = 1'b0;
        exp_overrun  = 1'b0;
        exp_tx_busy  = 1'b0;
        errors       = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(24760));
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        test_reset();
        report_test("reset");
        test_gpio();
        report_test("gpio");
        test_transmit(3);
        report_test("transmit");
        bus_write(ADDR_DIVIDER, 32'd11);
        test_transmit(3);
        report_test("transmit divider 11");
        test_receive();
        report_test("receive");
        test_framing();
        report_test("framing error");
        test_heartbeat();
        report_test("heartbeat");

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- uart/uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_rx
        (
            input   var logic                       clk,
            input   var logic                       reset,
            input   var logic                       rx_line,
            input   var pmod_uart_pkg::divider_t    divider,
            output  var logic                       rx_valid,
            output  var pmod_uart_pkg::uart_byte_t  rx_data,
            output  var logic                       rx_busy
        );

    import pmod_uart_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } state_t;

    state_t     state;
    logic       rx_meta;
    logic       rx_sync;
    logic       rx_prev;
    logic       rx_fall;
    divider_t   bit_div;
    divider_t   bit_cnt;
    logic [2:0] bit_idx;
    uart_byte_t shift;
    logic       half_end;
    logic       bit_end;

    // ------------------------------
    //  input synchronizer
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx_line;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign rx_fall  = rx_prev && !rx_sync;
    assign half_end = (bit_cnt == (bit_div >> 1));
    assign bit_end  = (bit_cnt == bit_div);

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= IDLE;
            bit_cnt <= '0;
            bit_idx <= '0;
        end else begin
            bit_cnt <= bit_end ? '0 : bit_cnt + 1'b1;
            case (state)
                IDLE: begin
                    bit_cnt <= '0;
                    if (rx_fall) begin
                        state <= START;
                    end
                end
                START: begin
                    // glitch check at mid start bit
                    if (half_end) begin
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? IDLE : DATA;
                    end
                end
                DATA: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            state <= STOP;
                        end else begin
                            bit_idx <= bit_idx + 3'd1;
                        end
                    end
                end
                STOP: begin
                    if (bit_end) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && rx_fall) begin
            bit_div <= divider;
        end
        if (state == DATA && bit_end) begin
            shift <= {rx_sync, shift[7:1]};
        end
    end

    // low stop bit drops the byte
    assign rx_valid = (state == STOP) && bit_end && rx_sync;
    assign rx_data  = shift;
    assign rx_busy  = (state != IDLE);

    a_valid_single: assert property (@(posedge clk) disable iff (reset)
        rx_valid |=> !rx_valid);

endmodule

`default_nettype wire

//--- uart/uart_tx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx
        (
            input   var logic                       clk,
            input   var logic                       reset,
            input   var logic                       tx_start,
            input   var pmod_uart_pkg::uart_byte_t  tx_data,
            input   var pmod_uart_pkg::divider_t    divider,
            output  var logic                       tx_busy,
            output  var logic                       tx_line
        );

    import pmod_uart_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } state_t;

    state_t     state;
    divider_t   bit_div;
    divider_t   bit_cnt;
    logic [2:0] bit_idx;
    uart_byte_t shift;
    logic       bit_end;

    assign bit_end = (bit_cnt == bit_div);
    assign tx_busy = (state != IDLE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= IDLE;
            bit_cnt <= '0;
            bit_idx <= '0;
            tx_line <= 1'b1;
        end else begin
            bit_cnt <= bit_end ? '0 : bit_cnt + 1'b1;
            case (state)
                IDLE: begin
                    bit_cnt <= '0;
                    if (tx_start) begin
                        state   <= START;
                        tx_line <= 1'b0;
                    end
                end
                START: begin
                    if (bit_end) begin
                        state   <= DATA;
                        bit_idx <= '0;
                        tx_line <= shift[0];
                    end
                end
                DATA: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            state   <= STOP;
                            tx_line <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 3'd1;
                            tx_line <= shift[0];
                        end
                    end
                end
                STOP: begin
                    if (bit_end) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // divider held for the whole frame, lsb first
    always_ff @(posedge clk) begin
        if (state == IDLE && tx_start) begin
            bit_div <= divider;
            shift   <= tx_data;
        end else if (state != IDLE && bit_end) begin
            shift <= shift >> 1;
        end
    end

    a_start_when_idle: assert property (@(posedge clk) disable iff (reset)
        tx_start |-> !tx_busy);

endmodule

`default_nettype wire
